// File: source/pspin_pkg.sv
// PsPIN scheduling package with sizes, descriptor formats and boot timing
package pspin_pkg;

  // System sizes
  localparam int NUM_CLUSTERS         = 4;
  localparam int NUM_HERS_PER_CLUSTER = 2;
  localparam int HER_QUEUE_DEPTH      = 4;
  localparam int BOOT_CYCLES          = 8;

  // Descriptor field widths
  localparam int MSG_ID_WIDTH         = 8;
  localparam int PKT_ADDR_WIDTH       = 16;
  localparam int PKT_LEN_WIDTH        = 12;
  localparam int HANDLER_CYCLES_WIDTH = 6;
  localparam int CLUSTER_ID_WIDTH     = 2;

  // Derived counter and pointer widths
  localparam int QUEUE_PTR_WIDTH = (HER_QUEUE_DEPTH > 1) ? $clog2(HER_QUEUE_DEPTH) : 1;
  localparam int QUEUE_CNT_WIDTH = $clog2(HER_QUEUE_DEPTH + 1);
  localparam int SLOT_PTR_WIDTH  = (NUM_HERS_PER_CLUSTER > 1) ? $clog2(NUM_HERS_PER_CLUSTER) : 1;
  localparam int SLOT_CNT_WIDTH  = $clog2(NUM_HERS_PER_CLUSTER + 1);
  localparam int CREDIT_WIDTH    = $clog2(NUM_HERS_PER_CLUSTER + 1);
  localparam int BOOT_CNT_WIDTH  = $clog2(BOOT_CYCLES + 1);

  typedef logic [CLUSTER_ID_WIDTH-1:0] cluster_id_t;

  // Handler execution request from the NIC inbound engine
  typedef struct packed {
    logic [MSG_ID_WIDTH-1:0]         msg_id;
    logic [PKT_ADDR_WIDTH-1:0]       pkt_addr;
    logic [PKT_LEN_WIDTH-1:0]        pkt_len;
    logic [HANDLER_CYCLES_WIDTH-1:0] handler_cycles;
    logic                            pinned;
  } her_descr_t;

  // Task as seen by a cluster, pinning already resolved
  typedef struct packed {
    logic [MSG_ID_WIDTH-1:0]         msg_id;
    logic [PKT_ADDR_WIDTH-1:0]       pkt_addr;
    logic [PKT_LEN_WIDTH-1:0]        pkt_len;
    logic [HANDLER_CYCLES_WIDTH-1:0] handler_cycles;
  } handler_task_t;

  // Completion notice back to the NIC
  typedef struct packed {
    logic [MSG_ID_WIDTH-1:0]   msg_id;
    logic [PKT_ADDR_WIDTH-1:0] pkt_addr;
    logic [PKT_LEN_WIDTH-1:0]  pkt_len;
    cluster_id_t               cluster_id;
  } feedback_descr_t;

endpackage

// File: source/her_queue.sv
// HER queue, a circular FIFO that buffers handler execution requests from the NIC
module her_queue (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  her_valid_i,
  output logic                  her_ready_o,
  input  pspin_pkg::her_descr_t her_i,
  output logic                  req_valid_o,
  input  logic                  req_ready_i,
  output pspin_pkg::her_descr_t req_o
);
  import pspin_pkg::*;

  her_descr_t                 mem_q [HER_QUEUE_DEPTH];
  logic [QUEUE_PTR_WIDTH-1:0] wr_ptr_q;
  logic [QUEUE_PTR_WIDTH-1:0] rd_ptr_q;
  logic [QUEUE_CNT_WIDTH-1:0] count_q;
  logic                       push;
  logic                       pop;

  // Full only when every entry is taken
  assign her_ready_o = (count_q != QUEUE_CNT_WIDTH'(HER_QUEUE_DEPTH));
  assign req_valid_o = (count_q != '0);
  assign req_o       = mem_q[rd_ptr_q];

  assign push = her_valid_i & her_ready_o;
  assign pop  = req_valid_o & req_ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= her_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == QUEUE_PTR_WIDTH'(HER_QUEUE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == QUEUE_PTR_WIDTH'(HER_QUEUE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leaves the fill level unchanged
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

// File: source/task_scheduler.sv
// Inter-cluster scheduler, picks a target cluster per request and tracks slot credits
module task_scheduler (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  logic                                   req_valid_i,
  output logic                                   req_ready_o,
  input  pspin_pkg::her_descr_t                  req_i,
  input  logic [pspin_pkg::NUM_CLUSTERS-1:0]     cluster_active_i,
  input  logic [pspin_pkg::NUM_CLUSTERS-1:0]     credit_return_i,
  output logic [pspin_pkg::NUM_CLUSTERS-1:0]     task_valid_o,
  output pspin_pkg::handler_task_t               task_o
);
  import pspin_pkg::*;

  logic [CREDIT_WIDTH-1:0] credit_q [NUM_CLUSTERS];
  cluster_id_t             target;
  logic                    found;
  logic                    accept;
  logic [NUM_CLUSTERS-1:0] take;

  always_comb begin
    found  = 1'b0;
    target = '0;
    if (req_i.pinned) begin
      target = cluster_id_t'(req_i.msg_id % NUM_CLUSTERS);
      found  = cluster_active_i[target] && (credit_q[target] != '0);
    end else begin
      // Scan downwards so the lowest eligible index is kept
      for (int i = NUM_CLUSTERS - 1; i >= 0; i--) begin
        if (cluster_active_i[i] && (credit_q[i] != '0)) begin
          found  = 1'b1;
          target = cluster_id_t'(i);
        end
      end
    end
  end

  // Stall while the chosen cluster cannot take another task
  assign req_ready_o = found;
  assign accept      = req_valid_i & found;
  assign take        = accept ? (NUM_CLUSTERS'(1) << target) : '0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      task_valid_o <= '0;
      for (int i = 0; i < NUM_CLUSTERS; i++) begin
        credit_q[i] <= CREDIT_WIDTH'(NUM_HERS_PER_CLUSTER);
      end
    end else begin
      task_valid_o <= take;
      for (int i = 0; i < NUM_CLUSTERS; i++) begin
        if (take[i] && !credit_return_i[i]) begin
          credit_q[i] <= credit_q[i] - 1'b1;
        end else if (credit_return_i[i] && !take[i]) begin
          credit_q[i] <= credit_q[i] + 1'b1;
        end
      end
    end
  end

  // Shared task bus, qualified by the one-hot valid
  always_ff @(posedge clk_i) begin
    if (accept) begin
      task_o.msg_id         <= req_i.msg_id;
      task_o.pkt_addr       <= req_i.pkt_addr;
      task_o.pkt_len        <= req_i.pkt_len;
      task_o.handler_cycles <= req_i.handler_cycles;
    end
  end

endmodule

// File: source/hpu_cluster.sv
// Handler cluster model with task slots, a handler timer and completion feedback
module hpu_cluster (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  pspin_pkg::cluster_id_t     cluster_id_i,
  input  logic                       task_valid_i,
  input  pspin_pkg::handler_task_t   task_i,
  output logic                       feedback_valid_o,
  input  logic                       feedback_ready_i,
  output pspin_pkg::feedback_descr_t feedback_o,
  output logic                       cluster_active_o
);
  import pspin_pkg::*;

  handler_task_t                   slot_q [NUM_HERS_PER_CLUSTER];
  logic [SLOT_PTR_WIDTH-1:0]       wr_ptr_q;
  logic [SLOT_PTR_WIDTH-1:0]       rd_ptr_q;
  logic [SLOT_CNT_WIDTH-1:0]       count_q;
  logic [BOOT_CNT_WIDTH-1:0]       boot_cnt_q;
  logic [HANDLER_CYCLES_WIDTH-1:0] timer_q;
  logic                            running_q;
  logic                            done_q;
  handler_task_t                   head;
  logic                            start;
  logic                            pop;

  assign head  = slot_q[rd_ptr_q];
  assign start = !running_q && !done_q && (count_q != '0);
  // Slot is freed only once the NIC side has taken the feedback
  assign pop   = done_q & feedback_ready_i;

  assign cluster_active_o = (boot_cnt_q == BOOT_CNT_WIDTH'(BOOT_CYCLES));
  assign feedback_valid_o = done_q;

  always_comb begin
    feedback_o.msg_id     = head.msg_id;
    feedback_o.pkt_addr   = head.pkt_addr;
    feedback_o.pkt_len    = head.pkt_len;
    feedback_o.cluster_id = cluster_id_i;
  end

  always_ff @(posedge clk_i) begin
    if (task_valid_i) begin
      slot_q[wr_ptr_q] <= task_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      boot_cnt_q <= '0;
      timer_q    <= '0;
      running_q  <= 1'b0;
      done_q     <= 1'b0;
    end else begin
      if (!cluster_active_o) begin
        boot_cnt_q <= boot_cnt_q + 1'b1;
      end
      if (task_valid_i) begin
        wr_ptr_q <= (wr_ptr_q == SLOT_PTR_WIDTH'(NUM_HERS_PER_CLUSTER - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == SLOT_PTR_WIDTH'(NUM_HERS_PER_CLUSTER - 1)) ? '0 : rd_ptr_q + 1'b1;
        done_q   <= 1'b0;
      end
      if (task_valid_i && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !task_valid_i) begin
        count_q <= count_q - 1'b1;
      end
      // Handler occupies handler_cycles+1 cycles
      if (start) begin
        timer_q   <= head.handler_cycles;
        running_q <= 1'b1;
      end else if (running_q) begin
        if (timer_q == '0) begin
          running_q <= 1'b0;
          done_q    <= 1'b1;
        end else begin
          timer_q <= timer_q - 1'b1;
        end
      end
    end
  end

endmodule

// File: source/feedback_arbiter.sv
// Feedback arbiter, round-robin over cluster completions into a one-entry NIC buffer
module feedback_arbiter (
  input  logic                                                clk_i,
  input  logic                                                reset_i,
  input  logic [pspin_pkg::NUM_CLUSTERS-1:0]                  fb_valid_i,
  output logic [pspin_pkg::NUM_CLUSTERS-1:0]                  fb_ready_o,
  input  pspin_pkg::feedback_descr_t [pspin_pkg::NUM_CLUSTERS-1:0] fb_i,
  output logic                                                nic_feedback_valid_o,
  input  logic                                                nic_feedback_ready_i,
  output pspin_pkg::feedback_descr_t                          nic_feedback_o,
  output logic [pspin_pkg::NUM_CLUSTERS-1:0]                  credit_return_o
);
  import pspin_pkg::*;

  cluster_id_t rr_q;
  cluster_id_t grant_idx;
  logic        grant_found;
  logic        can_take;
  logic        take;

  // First valid cluster at or after the round-robin pointer
  always_comb begin
    int idx;
    grant_found = 1'b0;
    grant_idx   = rr_q;
    for (int k = 0; k < NUM_CLUSTERS; k++) begin
      idx = int'(rr_q) + k;
      if (idx >= NUM_CLUSTERS) begin
        idx = idx - NUM_CLUSTERS;
      end
      if (!grant_found && fb_valid_i[idx]) begin
        grant_found = 1'b1;
        grant_idx   = cluster_id_t'(idx);
      end
    end
  end

  // Buffer takes a new winner when empty or emptying this cycle
  assign can_take = !nic_feedback_valid_o || nic_feedback_ready_i;
  assign take     = can_take && grant_found;

  always_comb begin
    fb_ready_o = '0;
    if (take) begin
      fb_ready_o[grant_idx] = 1'b1;
    end
  end

  assign credit_return_o = fb_valid_i & fb_ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      nic_feedback_valid_o <= 1'b0;
      rr_q                 <= '0;
    end else if (take) begin
      nic_feedback_valid_o <= 1'b1;
      rr_q <= (grant_idx == cluster_id_t'(NUM_CLUSTERS - 1)) ? '0 : grant_idx + 1'b1;
    end else if (nic_feedback_ready_i) begin
      nic_feedback_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      nic_feedback_o <= fb_i[grant_idx];
    end
  end

endmodule

// File: source/pspin_top.sv
// PsPIN top, request queue into scheduler, handler clusters and feedback arbiter
module pspin_top (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       her_valid_i,
  output logic                       her_ready_o,
  input  pspin_pkg::her_descr_t      her_i,
  output logic                       nic_feedback_valid_o,
  input  logic                       nic_feedback_ready_i,
  output pspin_pkg::feedback_descr_t nic_feedback_o,
  output logic                       pspin_active_o
);
  import pspin_pkg::*;

  // Queue to scheduler
  logic                                  req_valid;
  logic                                  req_ready;
  her_descr_t                            req;

  // Scheduler to clusters
  logic [NUM_CLUSTERS-1:0]               task_valid;
  handler_task_t                         task_bus;

  // Clusters to arbiter and back
  logic [NUM_CLUSTERS-1:0]               fb_valid;
  logic [NUM_CLUSTERS-1:0]               fb_ready;
  feedback_descr_t [NUM_CLUSTERS-1:0]    fb;
  logic [NUM_CLUSTERS-1:0]               credit_return;
  logic [NUM_CLUSTERS-1:0]               cluster_active;

  // Active once every cluster has booted
  assign pspin_active_o = &cluster_active;

  her_queue i_her_queue (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .her_valid_i (her_valid_i),
    .her_ready_o (her_ready_o),
    .her_i       (her_i),
    .req_valid_o (req_valid),
    .req_ready_i (req_ready),
    .req_o       (req)
  );

  task_scheduler i_task_scheduler (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .req_valid_i      (req_valid),
    .req_ready_o      (req_ready),
    .req_i            (req),
    .cluster_active_i (cluster_active),
    .credit_return_i  (credit_return),
    .task_valid_o     (task_valid),
    .task_o           (task_bus)
  );

  for (genvar i = 0; i < NUM_CLUSTERS; i++) begin : gen_clusters
    hpu_cluster i_cluster (
      .clk_i            (clk_i),
      .reset_i          (reset_i),
      .cluster_id_i     (cluster_id_t'(i)),
      .task_valid_i     (task_valid[i]),
      .task_i           (task_bus),
      .feedback_valid_o (fb_valid[i]),
      .feedback_ready_i (fb_ready[i]),
      .feedback_o       (fb[i]),
      .cluster_active_o (cluster_active[i])
    );
  end

  feedback_arbiter i_feedback_arbiter (
    .clk_i                (clk_i),
    .reset_i              (reset_i),
    .fb_valid_i           (fb_valid),
    .fb_ready_o           (fb_ready),
    .fb_i                 (fb),
    .nic_feedback_valid_o (nic_feedback_valid_o),
    .nic_feedback_ready_i (nic_feedback_ready_i),
    .nic_feedback_o       (nic_feedback_o),
    .credit_return_o      (credit_return)
  );

endmodule

// File: dv/tb_clock_gen.sv
// Testbench clock source with a synchronous, active high reset pulse
module tb_clock_gen #(
  parameter int PERIOD       = 40,
  parameter int RESET_CYCLES = 5,
  parameter int DRIVE_DELAY  = 5
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD / 2);
      clk_o = ~clk_o;
    end
  end

  // Reset drops just after a rising edge, like the other stimulus
  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #DRIVE_DELAY;
    reset_o = 1'b0;
  end

endmodule

// File: dv/pspin_assert.sv
// Concurrent checks on the PsPIN top-level handshakes and reset behavior
module pspin_assert (
  input logic                       clk_i,
  input logic                       reset_i,
  input logic                       her_valid_i,
  input logic                       her_ready_o,
  input pspin_pkg::her_descr_t      her_i,
  input logic                       nic_feedback_valid_o,
  input logic                       nic_feedback_ready_i,
  input pspin_pkg::feedback_descr_t nic_feedback_o
);

  // Count of failed properties
  int fail_count = 0;

  // Request held stable by the NIC while the queue is full
  her_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    her_valid_i && !her_ready_o |=> her_valid_i && $stable(her_i))
    else begin
      $error("HER valid or data changed while stalled");
      fail_count++;
    end

  // Feedback held stable by the arbiter while the NIC stalls
  feedback_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    nic_feedback_valid_o && !nic_feedback_ready_i
    |=> nic_feedback_valid_o && $stable(nic_feedback_o))
    else begin
      $error("feedback valid or data changed while stalled");
      fail_count++;
    end

  feedback_reset: assert property (@(posedge clk_i)
    $past(reset_i) |-> !nic_feedback_valid_o)
    else begin
      $error("feedback valid high during reset");
      fail_count++;
    end

  queue_ready_after_reset: assert property (@(posedge clk_i)
    $fell(reset_i) |-> her_ready_o)
    else begin
      $error("HER ready low right after reset");
      fail_count++;
    end

endmodule

bind pspin_top pspin_assert i_pspin_assert (
  .clk_i                (clk_i),
  .reset_i              (reset_i),
  .her_valid_i          (her_valid_i),
  .her_ready_o          (her_ready_o),
  .her_i                (her_i),
  .nic_feedback_valid_o (nic_feedback_valid_o),
  .nic_feedback_ready_i (nic_feedback_ready_i),
  .nic_feedback_o       (nic_feedback_o)
);

// File: dv/pspin_tb.sv
// Directed testbench for the PsPIN scheduling path with a feedback scoreboard
module pspin_tb;
  import pspin_pkg::*;

  localparam int CLK_PERIOD      = 40;
  localparam int RESET_CYCLES    = 5;
  localparam int DRIVE_DELAY     = 5;
  localparam int SEED            = 36;
  localparam int BURST_COUNT     = 40;
  localparam int PINNED_COUNT    = 16;
  localparam int MAX_HANDLER     = (1 << HANDLER_CYCLES_WIDTH) - 1;
  localparam int INFLIGHT_MAX    = HER_QUEUE_DEPTH + NUM_CLUSTERS * NUM_HERS_PER_CLUSTER + 2;
  localparam int STALL_CYCLES    = 2 * MAX_HANDLER + 10;
  localparam int TOTAL_REQS      = 1 + BURST_COUNT + PINNED_COUNT + INFLIGHT_MAX + 1;
  localparam int WATCHDOG_CYCLES = TOTAL_REQS * (MAX_HANDLER + 8) + 2 * STALL_CYCLES + 500;

  logic            clk;
  logic            reset;
  logic            her_valid;
  logic            her_ready;
  her_descr_t      her;
  logic            fb_valid;
  logic            fb_ready;
  feedback_descr_t fb;
  logic            active;

  // Scoreboard of outstanding requests and per-cluster pinned order
  her_descr_t sent [int];
  int         pin_order [NUM_CLUSTERS][$];
  int         next_id;
  int         errors;
  int         tests_passed;
  int         tests_failed;

  tb_clock_gen #(
    .PERIOD       (CLK_PERIOD),
    .RESET_CYCLES (RESET_CYCLES),
    .DRIVE_DELAY  (DRIVE_DELAY)
  ) i_clock_gen (
    .clk_o   (clk),
    .reset_o (reset)
  );

  pspin_top DUT (
    .clk_i                (clk),
    .reset_i              (reset),
    .her_valid_i          (her_valid),
    .her_ready_o          (her_ready),
    .her_i                (her),
    .nic_feedback_valid_o (fb_valid),
    .nic_feedback_ready_i (fb_ready),
    .nic_feedback_o       (fb),
    .pspin_active_o       (active)
  );

  task automatic flag_error(input string msg);
    $display("error %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic next_drive_slot(input int n);
    repeat (n) @(posedge clk);
    #DRIVE_DELAY;
  endtask

  function automatic her_descr_t make_her(input logic pin);
    her_descr_t h;
    h.msg_id         = MSG_ID_WIDTH'(next_id);
    h.pkt_addr       = PKT_ADDR_WIDTH'($urandom);
    h.pkt_len        = PKT_LEN_WIDTH'($urandom);
    h.handler_cycles = HANDLER_CYCLES_WIDTH'($urandom);
    h.pinned         = pin;
    next_id++;
    return h;
  endfunction

  task automatic record_her(input her_descr_t h);
    sent[int'(h.msg_id)] = h;
    if (h.pinned) begin
      pin_order[int'(h.msg_id) % NUM_CLUSTERS].push_back(int'(h.msg_id));
    end
  endtask

  // Offer one request until the queue takes it and leave valid high
  task automatic send_her(input her_descr_t h);
    her       = h;
    her_valid = 1'b1;
    @(negedge clk);
    while (!her_ready) begin
      @(negedge clk);
    end
    record_her(h);
    next_drive_slot(1);
  endtask

  task automatic check_feedback(input feedback_descr_t f);
    her_descr_t h;
    int         id;
    int         c;
    id = int'(f.msg_id);
    c  = id % NUM_CLUSTERS;
    assert (sent.exists(id)) else flag_error($sformatf("unexpected feedback, msg_id %0d", id));
    if (sent.exists(id)) begin
      h = sent[id];
      assert (f.pkt_addr == h.pkt_addr && f.pkt_len == h.pkt_len) else begin
        flag_error($sformatf("msg_id %0d got addr %h len %h, expected addr %h len %h",
                             id, f.pkt_addr, f.pkt_len, h.pkt_addr, h.pkt_len));
      end
      if (h.pinned) begin
        assert (int'(f.cluster_id) == c) else begin
          flag_error($sformatf("pinned msg_id %0d ran on cluster %0d", id, f.cluster_id));
        end
        assert (pin_order[c].size() != 0 && pin_order[c][0] == id) else begin
          flag_error($sformatf("pinned msg_id %0d completed out of order", id));
        end
        for (int k = 0; k < pin_order[c].size(); k++) begin
          if (pin_order[c][k] == id) begin
            pin_order[c].delete(k);
            break;
          end
        end
      end
      sent.delete(id);
    end
  endtask

  // Take n feedback transfers, then expect a quiet output and an empty scoreboard
  task automatic collect_feedback(input int n, input int limit);
    int got;
    int cycles;
    got    = 0;
    cycles = 0;
    while (got < n && cycles < limit) begin
      @(negedge clk);
      cycles++;
      if (fb_valid && fb_ready) begin
        check_feedback(fb);
        got++;
      end
    end
    assert (got == n) else flag_error($sformatf("feedback missing, got %0d of %0d", got, n));
    repeat (4) begin
      @(negedge clk);
      assert (!fb_valid) else flag_error("extra feedback with nothing outstanding");
    end
    assert (sent.num() == 0) else flag_error($sformatf("%0d requests never completed", sent.num()));
    next_drive_slot(1);
  endtask

  task automatic finish_test(input string name, input int errors_before);
    if (errors == errors_before) begin
      tests_passed++;
      $display("%s: passed", name);
    end else begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, errors - errors_before);
    end
  endtask

  task automatic test_reset();
    int e0;
    int waited;
    e0 = errors;
    @(negedge clk);
    while (reset) begin
      @(negedge clk);
    end
    assert (!fb_valid) else flag_error("feedback valid high after reset");
    assert (her_ready) else flag_error("her_ready_o low after reset");
    assert (!active) else flag_error("pspin_active_o high before boot finished");
    waited = 0;
    while (!active && waited < BOOT_CYCLES + 4) begin
      @(negedge clk);
      waited++;
    end
    assert (active) else flag_error("pspin_active_o never rose after boot");
    next_drive_slot(1);
    finish_test("reset", e0);
  endtask

  task automatic test_single();
    int         e0;
    her_descr_t h;
    e0 = errors;
    h  = make_her(1'b0);
    fork
      begin
        send_her(h);
        her_valid = 1'b0;
      end
      collect_feedback(1, MAX_HANDLER + 40);
    join
    finish_test("single request", e0);
  endtask

  task automatic test_burst(input string name, input logic pin, input int count);
    int e0;
    e0 = errors;
    fork
      begin
        for (int i = 0; i < count; i++) begin
          send_her(make_her(pin));
        end
        her_valid = 1'b0;
      end
      collect_feedback(count, count * (MAX_HANDLER + 8) + 50);
    join
    finish_test(name, e0);
  endtask

  task automatic test_backpressure();
    int         e0;
    int         accepted;
    int         low_cycles;
    her_descr_t h;
    e0         = errors;
    accepted   = 0;
    low_cycles = 0;
    fb_ready   = 1'b0;
    h          = make_her(1'b0);
    her        = h;
    her_valid  = 1'b1;
    // Ready must stay low for longer than any handler before the pipe counts as full
    while (low_cycles < STALL_CYCLES && accepted <= INFLIGHT_MAX) begin
      @(negedge clk);
      if (her_ready) begin
        record_her(h);
        accepted++;
        low_cycles = 0;
        next_drive_slot(1);
        h   = make_her(1'b0);
        her = h;
      end else begin
        low_cycles++;
      end
    end
    assert (accepted <= INFLIGHT_MAX) else begin
      flag_error($sformatf("her_ready_o still high after %0d accepted requests", accepted));
    end
    if (low_cycles >= STALL_CYCLES) begin
      next_drive_slot(1);
    end
    fb_ready = 1'b1;
    fork
      begin
        send_her(h);
        her_valid = 1'b0;
      end
      collect_feedback(accepted + 1, (accepted + 1) * (MAX_HANDLER + 8) + 50);
    join
    finish_test("back-pressure", e0);
  endtask

  initial begin
    void'($urandom(SEED));
    her_valid    = 1'b0;
    her          = '0;
    fb_ready     = 1'b1;
    next_id      = 0;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    test_reset();
    test_single();
    test_burst("unpinned burst", 1'b0, BURST_COUNT);
    test_burst("pinned requests", 1'b1, PINNED_COUNT);
    test_backpressure();
    $display("tests passed %0d, failed %0d, errors %0d, assertion failures %0d",
             tests_passed, tests_failed, errors, DUT.i_pspin_assert.fail_count);
    if (tests_failed == 0 && errors == 0 && DUT.i_pspin_assert.fail_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog sized from the request count and the longest handler
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: project.f
source/pspin_pkg.sv
source/her_queue.sv
source/task_scheduler.sv
source/hpu_cluster.sv
source/feedback_arbiter.sv
source/pspin_top.sv
dv/tb_clock_gen.sv
dv/pspin_assert.sv
dv/pspin_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= pspin_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the run prints the pass line
test: $(SIM_BIN)
	./$(SIM_BIN) | tee /dev/stderr | grep -x "TEST OK" > /dev/null

clean:
	rm -rf $(OBJ_DIR)
